// File: pp_output_decode.sv
`timescale 1ns/1ps
`default_nettype none

module pp_output_decode (
	input  pp_pkg::pp_pattern_t pattern,
	output logic                y1, y2, y3, y4, y5, y6, y7,
	output logic                y8, y9, y10, y11, y12, y13, y14,
	output logic                y15, y16, y17, y18, y19, y20, y21,
	output logic                y22, y23, y24, y25, y26, y27, y28
);

	logic [pp_pkg::num_outputs-1:0] y_vec;

	assign y_vec = pp_pkg::pattern_table[pattern];

	// Bit k-1 of the table entry is output yk.
	assign y1 = y_vec[0];
	assign y2 = y_vec[1];
	assign y3 = y_vec[2];
	assign y4 = y_vec[3];
	assign y5 = y_vec[4];
	assign y6 = y_vec[5];
	assign y7 = y_vec[6];
	assign y8 = y_vec[7];
	assign y9 = y_vec[8];
	assign y10 = y_vec[9];
	assign y11 = y_vec[10];
	assign y12 = y_vec[11];
	assign y13 = y_vec[12];
	assign y14 = y_vec[13];
	assign y15 = y_vec[14];
	assign y16 = y_vec[15];
	assign y17 = y_vec[16];
	assign y18 = y_vec[17];
	assign y19 = y_vec[18];
	assign y20 = y_vec[19];
	assign y21 = y_vec[20];
	assign y22 = y_vec[21];
	assign y23 = y_vec[22];
	assign y24 = y_vec[23];
	assign y25 = y_vec[24];
	assign y26 = y_vec[25];
	assign y27 = y_vec[26];
	assign y28 = y_vec[27];

endmodule

`default_nettype wire

// File: pp_pkg.sv
`default_nettype none

package pp_pkg;

	localparam int num_inputs = 20;
	localparam int num_outputs = 28;

	// Controller states, numbered as in the original state chart.
	typedef enum logic [4:0] {
		st_s1 = 5'd1,
		st_s2 = 5'd2,
		st_s3 = 5'd3,
		st_s4 = 5'd4,
		st_s5 = 5'd5,
		st_s6 = 5'd6,
		st_s7 = 5'd7,
		st_s8 = 5'd8,
		st_s9 = 5'd9,
		st_s10 = 5'd10,
		st_s11 = 5'd11,
		st_s12 = 5'd12,
		st_s13 = 5'd13,
		st_s14 = 5'd14,
		st_s15 = 5'd15,
		st_s16 = 5'd16,
		st_s17 = 5'd17
	} pp_state_t;

	// Each code names the command set issued on entry to a state.
	typedef enum logic [3:0] {
		pat_none = 4'd0,
		pat_to_s2 = 4'd1,
		pat_to_s3 = 4'd2,
		pat_to_s4 = 4'd3,
		pat_to_s5 = 4'd4, // Shared with the s10 entry.
		pat_to_s6 = 4'd5,
		pat_to_s7 = 4'd6,
		pat_to_s8 = 4'd7,
		pat_to_s9 = 4'd8,
		pat_to_s11 = 4'd9,
		pat_to_s12 = 4'd10,
		pat_to_s13 = 4'd11,
		pat_to_s14 = 4'd12,
		pat_to_s15 = 4'd13,
		pat_to_s16 = 4'd14,
		pat_to_s17 = 4'd15
	} pp_pattern_t;

	// Bit k-1 drives output yk. Entries follow the code order above.
	localparam logic [num_outputs-1:0] pattern_table [16] = '{
		28'h0000000, // none
		28'h6000280, // y8 y10 y26 y27
		28'h0000017, // y1 y2 y3 y5
		28'h0020400, // y11 y18
		28'h8001040, // y7 y13 y28
		28'h0000068, // y4 y6 y7
		28'h0A08000, // y16 y22 y24
		28'h1080002, // y2 y20 y25
		28'h0400400, // y11 y23
		28'h0A04000, // y15 y22 y24
		28'h8090000, // y17 y20 y28
		28'h0002C00, // y11 y12 y14
		28'h0000114, // y3 y5 y9
		28'h22C0000, // y19 y20 y22 y26
		28'h0302000, // y14 y21 y22
		28'h0080060  // y6 y7 y20
	};

endpackage

`default_nettype wire

// File: pp_top.sv
`timescale 1ns/1ps
`default_nettype none

module pp_top (
	input  logic rst,
	input  logic clk,
	input  logic x1, x2, x3, x4, x5,
	input  logic x6, x7, x8, x9, x10,
	input  logic x11, x12, x13, x14, x15,
	input  logic x16, x17, x18, x19, x20,
	output logic y1, y2, y3, y4, y5, y6, y7,
	output logic y8, y9, y10, y11, y12, y13, y14,
	output logic y15, y16, y17, y18, y19, y20, y21,
	output logic y22, y23, y24, y25, y26, y27, y28
);

	pp_pkg::pp_state_t state;
	pp_pkg::pp_state_t next_state;
	pp_pkg::pp_pattern_t pattern;

	// The only storage in the controller. Outputs are Mealy, so they follow the
	// inputs within the cycle while the state moves on the next edge.
	always_ff @(posedge rst or negedge clk)
	begin
		if (!clk)
			state <= pp_pkg::st_s1;
		else
			state <= next_state;
	end

	// Port names match one to one.
	pp_transition u_transition (.*);

	pp_output_decode u_output_decode (.*);

endmodule

`default_nettype wire

// File: pp_transition.sv
`timescale 1ns/1ps
`default_nettype none

module pp_transition (
	input  pp_pkg::pp_state_t   state,
	input  logic                x1, x2, x3, x4, x5,
	input  logic                x6, x7, x8, x9, x10,
	input  logic                x11, x12, x13, x14, x15,
	input  logic                x16, x17, x18, x19, x20,
	output pp_pkg::pp_state_t   next_state,
	output pp_pkg::pp_pattern_t pattern
);

	typedef struct packed {
		pp_pkg::pp_state_t dest;
		pp_pkg::pp_pattern_t pat;
	} step_t;

	step_t step;

	assign next_state = step.dest;
	assign pattern = step.pat;

	// Rows are tested in order, first match wins.
	always_comb
	begin
		step = '{state, pp_pkg::pat_none}; // Uncovered rows hold the state quietly.
		case (state)
		pp_pkg::st_s1:
			if (x13 && x1 && x10)
				step = '{pp_pkg::st_s2, pp_pkg::pat_to_s2};
			else if (x13 && x1 && !x10 && x2 && x3 && x15)
				step = '{pp_pkg::st_s1, pp_pkg::pat_none};
			else if (x13 && x1 && !x10 && x2 && x3 && !x15)
				step = '{pp_pkg::st_s3, pp_pkg::pat_to_s3};
			else if (x13 && x1 && !x10 && x2 && !x3 && x4 && x5)
				step = '{pp_pkg::st_s4, pp_pkg::pat_to_s4};
			else if (x13 && x1 && !x10 && x2 && !x3 && x4 && !x5)
				step = '{pp_pkg::st_s5, pp_pkg::pat_to_s5};
			else if (x13 && x1 && !x10 && x2 && !x3 && !x4)
				step = '{pp_pkg::st_s2, pp_pkg::pat_to_s2};
			else if (x13 && x1 && !x10 && !x2)
				step = '{pp_pkg::st_s6, pp_pkg::pat_to_s6};
			else if (x13 && !x1 && x10 && x2)
				step = '{pp_pkg::st_s7, pp_pkg::pat_to_s7};
			else if (x13 && !x1 && x10 && !x2 && x15)
				step = '{pp_pkg::st_s7, pp_pkg::pat_to_s7};
			else if (x13 && !x1 && x10 && !x2 && !x15)
				step = '{pp_pkg::st_s3, pp_pkg::pat_to_s3};
			else if (x13 && !x1 && !x10)
				step = '{pp_pkg::st_s7, pp_pkg::pat_to_s7};
			else if (!x13 && x12)
				step = '{pp_pkg::st_s6, pp_pkg::pat_to_s6};
			else if (!x13 && !x12 && x10 && x1)
				step = '{pp_pkg::st_s2, pp_pkg::pat_to_s2};
			else if (!x13 && !x12 && x10 && !x1 && x4)
				step = '{pp_pkg::st_s7, pp_pkg::pat_to_s7};
			else if (!x13 && !x12 && x10 && !x1 && !x4)
				step = '{pp_pkg::st_s3, pp_pkg::pat_to_s3};
			else if (!x13 && !x12 && !x10)
				step = '{pp_pkg::st_s6, pp_pkg::pat_to_s6}; // Idle path out of reset.
		pp_pkg::st_s2:
			if (x13 && x10 && x3 && x5)
				step = '{pp_pkg::st_s8, pp_pkg::pat_to_s8};
			else if (x13 && x10 && x3 && !x5)
				step = '{pp_pkg::st_s9, pp_pkg::pat_to_s9};
			else if (x13 && x10 && !x3)
				step = '{pp_pkg::st_s4, pp_pkg::pat_to_s4};
			else if (x13 && !x10)
				step = '{pp_pkg::st_s5, pp_pkg::pat_to_s5};
			else if (!x13 && x12)
				step = '{pp_pkg::st_s3, pp_pkg::pat_to_s3};
			else if (!x13 && !x12 && x5 && x10)
				step = '{pp_pkg::st_s7, pp_pkg::pat_to_s7};
			else if (!x13 && !x12 && x5 && !x10 && x3)
				step = '{pp_pkg::st_s10, pp_pkg::pat_to_s5};
			else if (!x13 && !x12 && x5 && !x10 && !x3 && x4)
				step = '{pp_pkg::st_s11, pp_pkg::pat_to_s11};
			else if (!x13 && !x12 && x5 && !x10 && !x3 && !x4)
				step = '{pp_pkg::st_s9, pp_pkg::pat_to_s9};
			else if (!x13 && !x12 && !x5 && x10)
				step = '{pp_pkg::st_s9, pp_pkg::pat_to_s9};
			else if (!x13 && !x12 && !x5 && !x10)
				step = '{pp_pkg::st_s5, pp_pkg::pat_to_s5};
		pp_pkg::st_s3:
			if (x13 && x10 && x9)
				step = '{pp_pkg::st_s5, pp_pkg::pat_to_s5};
			else if (x13 && x10 && !x9 && x17)
				step = '{pp_pkg::st_s7, pp_pkg::pat_to_s7};
			else if (x13 && x10 && !x9 && !x17)
				step = '{pp_pkg::st_s3, pp_pkg::pat_to_s3};
			else if (x13 && !x10)
				step = '{pp_pkg::st_s4, pp_pkg::pat_to_s4};
			else if (!x13 && x12 && x4)
				step = '{pp_pkg::st_s4, pp_pkg::pat_to_s4};
			else if (!x13 && x12 && !x4)
				step = '{pp_pkg::st_s1, pp_pkg::pat_none};
			else if (!x13 && !x12 && x10 && x2 && x16)
				step = '{pp_pkg::st_s8, pp_pkg::pat_to_s8};
			else if (!x13 && !x12 && x10 && x2 && !x16)
				step = '{pp_pkg::st_s9, pp_pkg::pat_to_s9};
			else if (!x13 && !x12 && x10 && !x2)
				step = '{pp_pkg::st_s4, pp_pkg::pat_to_s4};
			else if (!x13 && !x12 && !x10 && x18 && x3)
				step = '{pp_pkg::st_s10, pp_pkg::pat_to_s5};
			else if (!x13 && !x12 && !x10 && x18 && !x3 && x4)
				step = '{pp_pkg::st_s11, pp_pkg::pat_to_s11};
			else if (!x13 && !x12 && !x10 && x18 && !x3 && !x4)
				step = '{pp_pkg::st_s9, pp_pkg::pat_to_s9};
			else if (!x13 && !x12 && !x10 && !x18)
				step = '{pp_pkg::st_s4, pp_pkg::pat_to_s4};
		pp_pkg::st_s4:
			if (x13 && x10 && x6)
				step = '{pp_pkg::st_s2, pp_pkg::pat_to_s2};
			else if (x13 && x10 && !x6 && x4)
				step = '{pp_pkg::st_s7, pp_pkg::pat_to_s7};
			else if (x13 && x10 && !x6 && !x4)
				step = '{pp_pkg::st_s1, pp_pkg::pat_none};
			else if (x13 && !x10)
				step = '{pp_pkg::st_s1, pp_pkg::pat_none};
			else if (!x13 && x12)
				step = '{pp_pkg::st_s9, pp_pkg::pat_to_s9};
			else if (!x13 && !x12 && x10)
				step = '{pp_pkg::st_s12, pp_pkg::pat_to_s12};
			else if (!x13 && !x12 && !x10)
				step = '{pp_pkg::st_s9, pp_pkg::pat_to_s9};
		pp_pkg::st_s5:
			if (x13 && x10 && x7)
				step = '{pp_pkg::st_s2, pp_pkg::pat_to_s2};
			else if (x13 && x10 && !x7)
				step = '{pp_pkg::st_s9, pp_pkg::pat_to_s9};
			else if (x13 && !x10)
				step = '{pp_pkg::st_s1, pp_pkg::pat_none};
			else if (!x13 && x12 && x15 && x9)
				step = '{pp_pkg::st_s5, pp_pkg::pat_none};
			else if (!x13 && x12 && x15 && !x9)
				step = '{pp_pkg::st_s9, pp_pkg::pat_to_s9};
			else if (!x13 && x12 && !x15)
				step = '{pp_pkg::st_s3, pp_pkg::pat_to_s3};
			else if (!x13 && !x12)
				step = '{pp_pkg::st_s4, pp_pkg::pat_to_s4};
		pp_pkg::st_s6:
			if (x13 && x10 && x9)
				step = '{pp_pkg::st_s5, pp_pkg::pat_to_s5};
			else if (x13 && x10 && !x9 && x17)
				step = '{pp_pkg::st_s7, pp_pkg::pat_to_s7};
			else if (x13 && x10 && !x9 && !x17)
				step = '{pp_pkg::st_s3, pp_pkg::pat_to_s3};
			else if (x13 && !x10)
				step = '{pp_pkg::st_s2, pp_pkg::pat_to_s2};
			else if (!x13 && x1 && x12 && x2)
				step = '{pp_pkg::st_s2, pp_pkg::pat_to_s2};
			else if (!x13 && x1 && x12 && !x2 && x3)
				step = '{pp_pkg::st_s7, pp_pkg::pat_to_s7};
			else if (!x13 && x1 && x12 && !x2 && !x3)
				step = '{pp_pkg::st_s6, pp_pkg::pat_none};
			else if (!x13 && x1 && !x12 && x5 && x3)
				step = '{pp_pkg::st_s10, pp_pkg::pat_to_s5};
			else if (!x13 && x1 && !x12 && x5 && !x3 && x4)
				step = '{pp_pkg::st_s11, pp_pkg::pat_to_s11};
			else if (!x13 && x1 && !x12 && x5 && !x3 && !x4)
				step = '{pp_pkg::st_s9, pp_pkg::pat_to_s9};
			else if (!x13 && x1 && !x12 && !x5)
				step = '{pp_pkg::st_s3, pp_pkg::pat_to_s3};
			else if (!x13 && !x1 && x12)
				step = '{pp_pkg::st_s5, pp_pkg::pat_to_s5};
			else if (!x13 && !x1 && !x12 && x2)
				step = '{pp_pkg::st_s2, pp_pkg::pat_to_s2};
			else if (!x13 && !x1 && !x12 && !x2)
				step = '{pp_pkg::st_s7, pp_pkg::pat_to_s7};
		pp_pkg::st_s7:
			if (x13 && x10 && x17)
				step = '{pp_pkg::st_s11, pp_pkg::pat_to_s11};
			else if (x13 && x10 && !x17 && x15)
				step = '{pp_pkg::st_s7, pp_pkg::pat_to_s7};
			else if (x13 && x10 && !x17 && !x15)
				step = '{pp_pkg::st_s3, pp_pkg::pat_to_s3};
			else if (x13 && !x10 && x3 && x15)
				step = '{pp_pkg::st_s7, pp_pkg::pat_none};
			else if (x13 && !x10 && x3 && !x15)
				step = '{pp_pkg::st_s3, pp_pkg::pat_to_s3};
			else if (x13 && !x10 && !x3 && x4 && x5)
				step = '{pp_pkg::st_s4, pp_pkg::pat_to_s4};
			else if (x13 && !x10 && !x3 && x4 && !x5)
				step = '{pp_pkg::st_s5, pp_pkg::pat_to_s5};
			else if (x13 && !x10 && !x3 && !x4)
				step = '{pp_pkg::st_s2, pp_pkg::pat_to_s2};
			else if (!x13 && x12 && x4)
				step = '{pp_pkg::st_s4, pp_pkg::pat_to_s4};
			else if (!x13 && x12 && !x4)
				step = '{pp_pkg::st_s1, pp_pkg::pat_none};
			else if (!x13 && !x12 && x10 && x11)
				step = '{pp_pkg::st_s1, pp_pkg::pat_none};
			else if (!x13 && !x12 && x10 && !x11)
				step = '{pp_pkg::st_s13, pp_pkg::pat_to_s13};
			else if (!x13 && !x12 && !x10)
				step = '{pp_pkg::st_s4, pp_pkg::pat_to_s4};
		pp_pkg::st_s8:
			if (x13)
				step = '{pp_pkg::st_s6, pp_pkg::pat_to_s6};
			else if (!x13 && x10 && x5)
				step = '{pp_pkg::st_s14, pp_pkg::pat_to_s14};
			else if (!x13 && x10 && !x5)
				step = '{pp_pkg::st_s15, pp_pkg::pat_to_s15};
			else if (!x13 && !x10)
				step = '{pp_pkg::st_s9, pp_pkg::pat_to_s9};
		pp_pkg::st_s9:
			if (x13 && x20)
				step = '{pp_pkg::st_s1, pp_pkg::pat_none};
			else if (x13 && !x20)
				step = '{pp_pkg::st_s4, pp_pkg::pat_to_s4};
			else if (!x13 && x12)
				step = '{pp_pkg::st_s1, pp_pkg::pat_none};
			else if (!x13 && !x12 && x10 && x3)
				step = '{pp_pkg::st_s2, pp_pkg::pat_to_s2};
			else if (!x13 && !x12 && x10 && !x3)
				step = '{pp_pkg::st_s10, pp_pkg::pat_to_s5};
			else if (!x13 && !x12 && !x10 && x19 && x16)
				step = '{pp_pkg::st_s16, pp_pkg::pat_to_s16};
			else if (!x13 && !x12 && !x10 && x19 && !x16)
				step = '{pp_pkg::st_s1, pp_pkg::pat_none};
			else if (!x13 && !x12 && !x10 && !x19)
				step = '{pp_pkg::st_s8, pp_pkg::pat_to_s8};
		pp_pkg::st_s10:
			if (x10 && x7)
				step = '{pp_pkg::st_s11, pp_pkg::pat_to_s11};
			else if (x10 && !x7)
				step = '{pp_pkg::st_s16, pp_pkg::pat_to_s16};
			else if (!x10)
				step = '{pp_pkg::st_s3, pp_pkg::pat_to_s3};
		pp_pkg::st_s11:
			if (x13 && x8 && x1)
				step = '{pp_pkg::st_s2, pp_pkg::pat_to_s2};
			else if (x13 && x8 && !x1 && x14)
				step = '{pp_pkg::st_s5, pp_pkg::pat_to_s5};
			else if (x13 && x8 && !x1 && !x14)
				step = '{pp_pkg::st_s3, pp_pkg::pat_to_s3};
			else if (x13 && !x8)
				step = '{pp_pkg::st_s8, pp_pkg::pat_to_s8};
			else if (!x13 && x10)
				step = '{pp_pkg::st_s1, pp_pkg::pat_none};
			else if (!x13 && !x10 && x6 && x7 && x5 && x3)
				step = '{pp_pkg::st_s10, pp_pkg::pat_to_s5};
			else if (!x13 && !x10 && x6 && x7 && x5 && !x3 && x4)
				step = '{pp_pkg::st_s11, pp_pkg::pat_to_s11};
			else if (!x13 && !x10 && x6 && x7 && x5 && !x3 && !x4)
				step = '{pp_pkg::st_s9, pp_pkg::pat_to_s9};
			else if (!x13 && !x10 && x6 && x7 && !x5)
				step = '{pp_pkg::st_s3, pp_pkg::pat_to_s3};
			else if (!x13 && !x10 && x6 && !x7 && x8)
				step = '{pp_pkg::st_s16, pp_pkg::pat_to_s16};
			else if (!x13 && !x10 && x6 && !x7 && !x8 && x5 && x3)
				step = '{pp_pkg::st_s10, pp_pkg::pat_to_s5};
			else if (!x13 && !x10 && x6 && !x7 && !x8 && x5 && !x3 && x4)
				step = '{pp_pkg::st_s11, pp_pkg::pat_to_s11};
			else if (!x13 && !x10 && x6 && !x7 && !x8 && x5 && !x3 && !x4)
				step = '{pp_pkg::st_s9, pp_pkg::pat_to_s9};
			else if (!x13 && !x10 && x6 && !x7 && !x8 && !x5)
				step = '{pp_pkg::st_s3, pp_pkg::pat_to_s3};
			else if (!x13 && !x10 && !x6 && x16)
				step = '{pp_pkg::st_s16, pp_pkg::pat_to_s16};
			else if (!x13 && !x10 && !x6 && !x16)
				step = '{pp_pkg::st_s1, pp_pkg::pat_none};
		pp_pkg::st_s12:
			if (x6)
				step = '{pp_pkg::st_s17, pp_pkg::pat_to_s17};
			else
				step = '{pp_pkg::st_s15, pp_pkg::pat_to_s15};
		pp_pkg::st_s13:
			if (x9)
				step = '{pp_pkg::st_s7, pp_pkg::pat_to_s7};
			else
				step = '{pp_pkg::st_s11, pp_pkg::pat_to_s11};
		pp_pkg::st_s14:
			step = '{pp_pkg::st_s5, pp_pkg::pat_to_s5};
		pp_pkg::st_s15:
			if (x8)
				step = '{pp_pkg::st_s3, pp_pkg::pat_to_s3};
			else
				step = '{pp_pkg::st_s17, pp_pkg::pat_to_s17};
		pp_pkg::st_s16:
			if (x10 && x15)
				step = '{pp_pkg::st_s1, pp_pkg::pat_none};
			else if (x10 && !x15)
				step = '{pp_pkg::st_s7, pp_pkg::pat_to_s7};
			else if (!x10)
				step = '{pp_pkg::st_s1, pp_pkg::pat_none};
		pp_pkg::st_s17:
			step = '{pp_pkg::st_s3, pp_pkg::pat_to_s3};
		default:
			step = '{pp_pkg::st_s1, pp_pkg::pat_none}; // Recover from an illegal encoding.
		endcase
	end

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_pp -f tb.f -o tb_pp_sim \
	&& ./obj_dir/tb_pp_sim > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "Build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "Test failed" sim.log && { echo "Simulation FAILED"; exit 1; } \
	|| { echo "Simulation PASSED"; exit 0; }

// File: tb.f
pp_pkg.sv
pp_transition.sv
pp_output_decode.sv
pp_top.sv
tb_clock_gen.sv
tb_pp.sv

// File: tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
	parameter real period_ns = 4.0,
	parameter int reset_cycles = 4
) (
	output logic rst,
	output logic clk
);

	initial
	begin
		rst = 1'b0;
		forever
			#(period_ns / 2.0) rst = ~rst;
	end

	// Reset falls just after time zero, so the state register sees a falling edge.
	// Release lands half a nanosecond after an edge, well clear of the next one.
	initial
	begin
		clk = 1'b1;
		#0.5;
		clk = 1'b0;
		repeat (reset_cycles) @(posedge rst);
		#0.5;
		clk = 1'b1;
	end

endmodule

`default_nettype wire

// File: tb_pp.sv
`timescale 1ns/1ps
`default_nettype none

module tb_pp;

	localparam real clk_period = 4.0;
	localparam int random_cycles = 2000;
	localparam real watchdog_ns = (random_cycles + 1000) * clk_period;

	wire rst;
	wire por_n;
	wire clk;
	wire [27:0] y_vec;

	logic pulse_n;
	logic [19:0] x_vec;
	logic [27:0] exp_vec;
	logic exp_en;
	logic [31:0] lfsr;
	int error_count;
	int tests_passed;
	int tests_failed;

	assign clk = por_n & pulse_n; // Power-on reset and mid-run pulses share one pin.

	tb_clock_gen #(.period_ns(clk_period), .reset_cycles(4)) u_clock_gen (
		.rst(rst),
		.clk(por_n)
	);

	pp_top u_pp_top (
		.rst(rst), .clk(clk),
		.x1(x_vec[0]), .x2(x_vec[1]), .x3(x_vec[2]), .x4(x_vec[3]), .x5(x_vec[4]),
		.x6(x_vec[5]), .x7(x_vec[6]), .x8(x_vec[7]), .x9(x_vec[8]), .x10(x_vec[9]),
		.x11(x_vec[10]), .x12(x_vec[11]), .x13(x_vec[12]), .x14(x_vec[13]),
		.x15(x_vec[14]), .x16(x_vec[15]), .x17(x_vec[16]), .x18(x_vec[17]),
		.x19(x_vec[18]), .x20(x_vec[19]),
		.y1(y_vec[0]), .y2(y_vec[1]), .y3(y_vec[2]), .y4(y_vec[3]), .y5(y_vec[4]),
		.y6(y_vec[5]), .y7(y_vec[6]), .y8(y_vec[7]), .y9(y_vec[8]), .y10(y_vec[9]),
		.y11(y_vec[10]), .y12(y_vec[11]), .y13(y_vec[12]), .y14(y_vec[13]),
		.y15(y_vec[14]), .y16(y_vec[15]), .y17(y_vec[16]), .y18(y_vec[17]),
		.y19(y_vec[18]), .y20(y_vec[19]), .y21(y_vec[20]), .y22(y_vec[21]),
		.y23(y_vec[22]), .y24(y_vec[23]), .y25(y_vec[24]), .y26(y_vec[25]),
		.y27(y_vec[26]), .y28(y_vec[27])
	);

	function automatic logic [19:0] xb(input int k);
		xb = 20'd1 << (k - 1);
	endfunction

	function automatic logic [27:0] yb(input int k);
		yb = 28'd1 << (k - 1);
	endfunction

	// Output sets written out from the command list of each pattern code.
	function automatic logic [27:0] pattern_bits(input pp_pkg::pp_pattern_t code);
		case (code)
		pp_pkg::pat_to_s2: pattern_bits = yb(8) | yb(10) | yb(26) | yb(27);
		pp_pkg::pat_to_s3: pattern_bits = yb(1) | yb(2) | yb(3) | yb(5);
		pp_pkg::pat_to_s4: pattern_bits = yb(11) | yb(18);
		pp_pkg::pat_to_s5: pattern_bits = yb(7) | yb(13) | yb(28);
		pp_pkg::pat_to_s6: pattern_bits = yb(4) | yb(6) | yb(7);
		pp_pkg::pat_to_s7: pattern_bits = yb(16) | yb(22) | yb(24);
		pp_pkg::pat_to_s8: pattern_bits = yb(2) | yb(20) | yb(25);
		pp_pkg::pat_to_s9: pattern_bits = yb(11) | yb(23);
		pp_pkg::pat_to_s11: pattern_bits = yb(15) | yb(22) | yb(24);
		pp_pkg::pat_to_s12: pattern_bits = yb(17) | yb(20) | yb(28);
		pp_pkg::pat_to_s13: pattern_bits = yb(11) | yb(12) | yb(14);
		pp_pkg::pat_to_s14: pattern_bits = yb(3) | yb(5) | yb(9);
		pp_pkg::pat_to_s15: pattern_bits = yb(19) | yb(20) | yb(22) | yb(26);
		pp_pkg::pat_to_s16: pattern_bits = yb(14) | yb(21) | yb(22);
		pp_pkg::pat_to_s17: pattern_bits = yb(6) | yb(7) | yb(20);
		default: pattern_bits = '0;
		endcase
	endfunction

	function automatic logic is_legal(input logic [27:0] v);
		logic found;
		found = 1'b0;
		for (int i = 0; i < 16; i++)
			if (v == pattern_bits(pp_pkg::pp_pattern_t'(i[3:0])))
				found = 1'b1;
		return found;
	endfunction

	// Fibonacci LFSR with taps 32, 22, 2 and 1.
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		lfsr_next = {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	expected_outputs: assert property (@(posedge rst) exp_en |-> y_vec == exp_vec)
		else
		begin
			$display("mismatch at %0t: outputs %h, expected %h", $time,
				$sampled(y_vec), $sampled(exp_vec));
			error_count++;
		end

	reset_outputs: assert property (@(posedge rst)
		(!clk && x_vec == '0) |-> y_vec == pattern_bits(pp_pkg::pat_to_s6))
		else
		begin
			$display("mismatch at %0t: outputs %h under reset", $time, $sampled(y_vec));
			error_count++;
		end

	legal_outputs: assert property (@(posedge rst) is_legal(y_vec))
		else
		begin
			$display("mismatch at %0t: outputs %h match no pattern", $time, $sampled(y_vec));
			error_count++;
		end

	task automatic draw_inputs(output logic [19:0] v);
		for (int k = 0; k < 20; k++)
		begin
			lfsr = lfsr_next(lfsr);
			v[k] = lfsr[0];
		end
	endtask

	// Called half a nanosecond after an edge and returns at the same point of the next cycle.
	task automatic apply_step(input logic [19:0] inputs, input pp_pkg::pp_pattern_t code);
		x_vec = inputs;
		exp_vec = pattern_bits(code);
		exp_en = 1'b1;
		@(posedge rst);
		#0.5;
	endtask

	task automatic pulse_reset();
		x_vec = '0;
		exp_en = 1'b0;
		#0.5;
		pulse_n = 1'b0;
		@(posedge rst);
		#0.5;
		pulse_n = 1'b1; // The state is st_s1 for the next step.
	endtask

	task automatic run_random(input int cycles);
		logic [19:0] v;
		exp_en = 1'b0;
		repeat (cycles)
		begin
			draw_inputs(v);
			x_vec = v;
			@(posedge rst);
			#0.5;
		end
	endtask

	task automatic report_test(input string name, input int errs);
		if (errs == 0)
		begin
			tests_passed++;
			$display("%s: passed", name);
		end
		else
		begin
			tests_failed++;
			$display("%s: failed with %0d errors", name, errs);
		end
	endtask

	initial
	begin
		#(watchdog_ns);
		$display("Timeout: the run did not finish within %0t", $time);
		$display("Test failed");
		$finish;
	end

	initial
	begin
		int mark;
		int part1;
		logic [19:0] rand_x;
		x_vec = '0;
		pulse_n = 1'b1;
		lfsr = 32'hb70f;
		error_count = 0;
		tests_passed = 0;
		tests_failed = 0;
		exp_vec = pattern_bits(pp_pkg::pat_to_s6); // Idle pattern while reset is held.
		exp_en = 1'b1;

		mark = error_count;
		@(negedge por_n); // Reset asserts just after time zero.
		@(posedge por_n);
		apply_step(xb(13) | xb(1) | xb(10), pp_pkg::pat_to_s2);
		report_test("reset state", error_count - mark);

		mark = error_count;
		pulse_reset();
		apply_step(xb(13) | xb(1) | xb(10), pp_pkg::pat_to_s2);
		apply_step(xb(13), pp_pkg::pat_to_s5);
		apply_step(xb(13), pp_pkg::pat_none);
		apply_step('0, pp_pkg::pat_to_s6);
		report_test("directed walk", error_count - mark);

		// Every pass through s13 must come back to s7.
		mark = error_count;
		pulse_reset();
		apply_step(xb(13), pp_pkg::pat_to_s7);
		repeat (6)
		begin
			apply_step(xb(10), pp_pkg::pat_to_s13);
			apply_step(xb(9), pp_pkg::pat_to_s7);
		end
		report_test("s13 loop", error_count - mark);

		mark = error_count;
		pulse_reset();
		apply_step(xb(13) | xb(1) | xb(10), pp_pkg::pat_to_s2);
		apply_step(xb(13) | xb(10) | xb(3) | xb(5), pp_pkg::pat_to_s8);
		apply_step(xb(10) | xb(5), pp_pkg::pat_to_s14);
		draw_inputs(rand_x);
		apply_step(rand_x, pp_pkg::pat_to_s5);
		report_test("unconditional s14", error_count - mark);

		mark = error_count;
		run_random(random_cycles / 2);
		part1 = error_count - mark;

		mark = error_count;
		pulse_reset();
		apply_step(xb(13) | xb(1) | xb(10), pp_pkg::pat_to_s2);
		report_test("async reset", error_count - mark);

		mark = error_count;
		run_random(random_cycles - random_cycles / 2);
		report_test("random legal outputs", part1 + error_count - mark);

		$display("Tests passed: %0d, tests failed: %0d, assertion errors: %0d",
			tests_passed, tests_failed, error_count);
		if (tests_failed == 0 && error_count == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire
